// ==== hdl/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

    localparam logic [31:0] RESET_VECTOR = 32'h100;
    localparam logic [3:0]  PC_IDX       = 4'd15;     // reads next pc, write branches

    localparam logic [3:0] OP_OR      = 4'h0;
    localparam logic [3:0] OP_AND     = 4'h1;
    localparam logic [3:0] OP_XOR     = 4'h2;
    localparam logic [3:0] OP_SRA     = 4'h3;
    localparam logic [3:0] OP_ADD     = 4'h4;
    localparam logic [3:0] OP_MUL     = 4'h5;
    localparam logic [3:0] OP_EQ      = 4'h6;
    localparam logic [3:0] OP_LT      = 4'h7;
    localparam logic [3:0] OP_ORN     = 4'h8;
    localparam logic [3:0] OP_ANDN    = 4'h9;
    localparam logic [3:0] OP_PACK    = 4'ha;
    localparam logic [3:0] OP_SRL     = 4'hb;
    localparam logic [3:0] OP_SUB     = 4'hc;
    localparam logic [3:0] OP_SHL     = 4'hd;
    localparam logic [3:0] OP_TESTBIT = 4'he;
    localparam logic [3:0] OP_GE      = 4'hf;

    typedef struct packed {
        logic [31:0] adr;
        logic [31:0] dat;
        logic        we;
        logic        stb;
        logic        cyc;
    } busReq_t;

    typedef struct packed {
        logic [31:0] dat;
        logic        ack;
        logic        err;
        logic        rty;
    } busRsp_t;

    typedef struct packed {
        logic [1:0]  kind;
        logic [3:0]  op;
        logic [3:0]  idxZ;
        logic [3:0]  idxX;
        logic [3:0]  idxY;
        logic [31:0] imm;
        logic        storing;
        logic        loading;
        logic        derefRhs;    // memory side uses result as address
        logic        branching;
    } decoded_t;

    typedef struct packed {
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
    } operands_t;

endpackage

`default_nettype wire

// ==== hdl/insnDecode.sv ====
`default_nettype none
`timescale 1ns/1ps

module insnDecode (
    input  wire logic [31:0]        insn_i,
    input  wire logic [31:0]        regX_i,
    input  wire logic [31:0]        regY_i,
    output cpuPkg::decoded_t        dec_o,
    output cpuPkg::operands_t       opnd_o
);

    logic [1:0]  kind;
    logic [1:0]  dd;
    logic [3:0]  idxZ;
    logic [3:0]  idxX;
    logic [19:0] tail;
    logic [3:0]  idxY;
    logic [3:0]  op;
    logic [31:0] imm;
    logic        storing;

    assign {kind, dd, idxZ, idxX, tail} = insn_i;

    always_comb begin
        if (kind == 2'd3) begin
            idxY = 4'd0;
            op   = cpuPkg::OP_OR;
            imm  = {{12{tail[19]}}, tail};      // long immediate
        end else begin
            idxY = tail[19:16];
            op   = tail[15:12];
            imm  = {{20{tail[11]}}, tail[11:0]};
        end
    end

    assign storing = dd[1] ^ dd[0];

    always_comb begin
        dec_o.kind      = kind;
        dec_o.op        = op;
        dec_o.idxZ      = idxZ;
        dec_o.idxX      = idxX;
        dec_o.idxY      = idxY;
        dec_o.imm       = imm;
        dec_o.storing   = storing;
        dec_o.loading   = dd[1] & dd[0];
        dec_o.derefRhs  = dd[0];
        dec_o.branching = (idxZ == cpuPkg::PC_IDX) && !storing;
    end

    // operand order by kind
    always_comb begin
        case (kind)
            2'd0:    opnd_o = '{a: regX_i, b: regY_i, c: imm};
            2'd1:    opnd_o = '{a: regX_i, b: imm,    c: regY_i};
            2'd2:    opnd_o = '{a: imm,    b: regX_i, c: regY_i};
            default: opnd_o = '{a: 32'd0,  b: regX_i, c: imm};
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/regFile.sv ====
`default_nettype none
`timescale 1ns/1ps

module regFile (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire logic [3:0]  idxX_i,
    input  wire logic [3:0]  idxY_i,
    input  wire logic [3:0]  idxZ_i,
    input  wire logic        wen_i,
    input  wire logic [31:0] wdata_i,
    input  wire logic [31:0] nextPc_i,
    output logic      [31:0] valX_o,
    output logic      [31:0] valY_o,
    output logic      [31:0] valZ_o
);

    logic [31:0] regs [0:14];

    function automatic logic [31:0] readReg(input logic [3:0] idx);
        if (idx == cpuPkg::PC_IDX)
            return nextPc_i;
        if (idx == 4'd0)
            return 32'd0;                       // hard zero
        return regs[idx];
    endfunction

    assign valX_o = readReg(idxX_i);
    assign valY_o = readReg(idxY_i);
    assign valZ_o = readReg(idxZ_i);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < 15; k++)
                regs[k] <= 32'd0;
        end else if (wen_i && idxZ_i != 4'd0 && idxZ_i != cpuPkg::PC_IDX) begin
            regs[idxZ_i] <= wdata_i;
        end
    end

    a_wenIdxKnown: assert property (@(posedge clk) disable iff (reset)
        wen_i |-> !$isunknown(idxZ_i));

endmodule

`default_nettype wire

// ==== hdl/execUnit.sv ====
`default_nettype none
`timescale 1ns/1ps

module execUnit (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic              start_i,
    input  wire logic [3:0]        op_i,
    input  cpuPkg::operands_t      opnd_i,
    output logic                   done_o,
    output logic      [31:0]       result_o
);

    logic              v1, v2, v3, v4;
    logic [3:0]        op1;
    cpuPkg::operands_t opnd1;
    logic [31:0]       opVal;
    logic [31:0]       y2;
    logic [31:0]       c2;
    logic [31:0]       z3;
    logic [4:0]        sh;

    assign sh = opnd1.b[4:0];       // shift amount

    always_comb begin
        case (op1)
            cpuPkg::OP_OR:      opVal = opnd1.a | opnd1.b;
            cpuPkg::OP_AND:     opVal = opnd1.a & opnd1.b;
            cpuPkg::OP_XOR:     opVal = opnd1.a ^ opnd1.b;
            cpuPkg::OP_SRA:     opVal = $signed(opnd1.a) >>> sh;
            cpuPkg::OP_ADD:     opVal = opnd1.a + opnd1.b;
            cpuPkg::OP_MUL:     opVal = opnd1.a * opnd1.b;   // low word
            cpuPkg::OP_EQ:      opVal = {32{opnd1.a == opnd1.b}};
            cpuPkg::OP_LT:      opVal = {32{$signed(opnd1.a) < $signed(opnd1.b)}};
            cpuPkg::OP_ORN:     opVal = opnd1.a | ~opnd1.b;
            cpuPkg::OP_ANDN:    opVal = opnd1.a & ~opnd1.b;
            cpuPkg::OP_PACK:    opVal = {opnd1.a[19:0], opnd1.b[11:0]};
            cpuPkg::OP_SRL:     opVal = opnd1.a >> sh;
            cpuPkg::OP_SUB:     opVal = opnd1.a - opnd1.b;
            cpuPkg::OP_SHL:     opVal = opnd1.a << sh;
            cpuPkg::OP_TESTBIT: opVal = {32{opnd1.a[sh]}};
            default:            opVal = {32{$signed(opnd1.a) >= $signed(opnd1.b)}};
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            {v1, v2, v3, v4} <= 4'b0;
        end else begin
            v1 <= start_i;
            v2 <= v1;
            v3 <= v2;
            v4 <= v3;
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            op1   <= op_i;
            opnd1 <= opnd_i;
        end
        if (v1) begin
            y2 <= opVal;
            c2 <= opnd1.c;
        end
        if (v2)
            z3 <= y2 + c2;
        if (v3)
            result_o <= z3;
    end

    assign done_o = v4;

    a_doneLatency: assert property (@(posedge clk) disable iff (reset)
        start_i |-> ##4 done_o);

endmodule

`default_nettype wire

// ==== hdl/busSequencer.sv ====
`default_nettype none
`timescale 1ns/1ps

module busSequencer (
    input  wire logic              clk,
    input  wire logic              reset,
    input  cpuPkg::decoded_t       dec_i,
    input  wire logic [31:0]       result_i,
    input  wire logic              done_i,
    input  wire logic [31:0]       valZ_i,
    output cpuPkg::busReq_t        insnReq_o,
    output cpuPkg::busReq_t        dataReq_o,
    input  cpuPkg::busRsp_t        insnRsp_i,
    input  cpuPkg::busRsp_t        dataRsp_i,
    output logic      [31:0]       insn_o,
    output logic                   start_o,
    output logic      [31:0]       nextPc_o,
    output logic                   regWen_o,
    output logic      [31:0]       regWdata_o,
    output logic                   halt_o
);

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        EXEC,
        ACCESS,
        WRBACK,
        ADVANCE
    } state_t;

    state_t      state;
    logic [31:0] pc;
    logic [31:0] insnReg;
    logic [31:0] resultReg;
    logic [31:0] loadReg;
    logic        startReg;
    logic        haltReg;
    logic        errNow;
    logic        memOp;

    assign memOp  = dec_i.storing | dec_i.loading;
    assign errNow = (insnReq_o.cyc & (insnRsp_i.err | insnRsp_i.rty))
                  | (dataReq_o.cyc & (dataRsp_i.err | dataRsp_i.rty));
    assign halt_o = haltReg | errNow;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= IDLE;
            pc       <= cpuPkg::RESET_VECTOR;
            startReg <= 1'b0;
            haltReg  <= 1'b0;
        end else begin
            startReg <= 1'b0;
            if (errNow) begin
                haltReg <= 1'b1;            // sticky until reset
                state   <= IDLE;
            end else begin
                case (state)
                    IDLE:    if (!haltReg) state <= FETCH;
                    FETCH: begin
                        if (insnRsp_i.ack) begin
                            state    <= EXEC;
                            startReg <= 1'b1;
                        end
                    end
                    EXEC:    if (done_i) state <= memOp ? ACCESS : WRBACK;
                    ACCESS:  if (dataRsp_i.ack) state <= WRBACK;
                    WRBACK:  state <= ADVANCE;
                    ADVANCE: begin
                        pc    <= dec_i.branching ? regWdata_o : nextPc_o;
                        state <= FETCH;
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == FETCH && insnRsp_i.ack)
            insnReg <= insnRsp_i.dat;
        if (state == EXEC && done_i)
            resultReg <= result_i;
        if (state == ACCESS && dataRsp_i.ack)
            loadReg <= dataRsp_i.dat;
    end

    assign insn_o   = insnReg;
    assign start_o  = startReg;
    assign nextPc_o = pc + 32'd1;

    assign insnReq_o.adr = pc;
    assign insnReq_o.dat = 32'd0;
    assign insnReq_o.we  = 1'b0;
    assign insnReq_o.stb = (state == FETCH);
    assign insnReq_o.cyc = (state == FETCH);

    // mode 01 and 11 address by result, mode 10 by Z
    assign dataReq_o.adr = dec_i.derefRhs ? resultReg : valZ_i;
    assign dataReq_o.dat = dec_i.derefRhs ? valZ_i : resultReg;
    assign dataReq_o.we  = (state == ACCESS) && dec_i.storing;
    assign dataReq_o.stb = (state == ACCESS);
    assign dataReq_o.cyc = (state == ACCESS);

    assign regWen_o   = (state == WRBACK) && !dec_i.storing;
    assign regWdata_o = dec_i.derefRhs ? loadReg : resultReg;

    a_insnHold: assert property (@(posedge clk) disable iff (reset || halt_o)
        insnReq_o.stb && !insnRsp_i.ack |=> insnReq_o.stb && $stable(insnReq_o.adr));

    a_dataHold: assert property (@(posedge clk) disable iff (reset || halt_o)
        dataReq_o.stb && !dataRsp_i.ack |=>
            dataReq_o.stb && $stable(dataReq_o.adr) && $stable(dataReq_o.dat)
            && $stable(dataReq_o.we));

    a_weNeedsStb: assert property (@(posedge clk) disable iff (reset)
        dataReq_o.we |-> dataReq_o.stb);

endmodule

`default_nettype wire

// ==== hdl/cpuTop.sv ====
`default_nettype none
`timescale 1ns/1ps

module cpuTop (
    input  wire logic          clk,
    input  wire logic          reset,
    output cpuPkg::busReq_t    insnReq_o,
    output cpuPkg::busReq_t    dataReq_o,
    input  cpuPkg::busRsp_t    insnRsp_i,
    input  cpuPkg::busRsp_t    dataRsp_i,
    output logic               halt_o
);

    cpuPkg::decoded_t  dec;
    cpuPkg::operands_t opnd;
    logic [31:0]       insn;
    logic [31:0]       valX, valY, valZ;
    logic [31:0]       nextPc;
    logic [31:0]       result;
    logic              done;
    logic              start;
    logic              regWen;
    logic [31:0]       regWdata;

    insnDecode insnDecode_inst (
        .insn_i (insn),
        .regX_i (valX),
        .regY_i (valY),
        .dec_o  (dec),
        .opnd_o (opnd)
    );

    regFile regFile_inst (
        .clk      (clk),
        .reset    (reset),
        .idxX_i   (dec.idxX),
        .idxY_i   (dec.idxY),
        .idxZ_i   (dec.idxZ),
        .wen_i    (regWen),
        .wdata_i  (regWdata),
        .nextPc_i (nextPc),
        .valX_o   (valX),
        .valY_o   (valY),
        .valZ_o   (valZ)
    );

    execUnit execUnit_inst (
        .clk      (clk),
        .reset    (reset),
        .start_i  (start),
        .op_i     (dec.op),
        .opnd_i   (opnd),
        .done_o   (done),
        .result_o (result)
    );

    busSequencer busSequencer_inst (
        .clk        (clk),
        .reset      (reset),
        .dec_i      (dec),
        .result_i   (result),
        .done_i     (done),
        .valZ_i     (valZ),
        .insnReq_o  (insnReq_o),
        .dataReq_o  (dataReq_o),
        .insnRsp_i  (insnRsp_i),
        .dataRsp_i  (dataRsp_i),
        .insn_o     (insn),
        .start_o    (start),
        .nextPc_o   (nextPc),
        .regWen_o   (regWen),
        .regWdata_o (regWdata),
        .halt_o     (halt_o)
    );

endmodule

`default_nettype wire

// ==== testbench/busModel.sv ====
`default_nettype none
`timescale 1ns/1ps

module busModel (
    input  wire logic            clk,
    input  wire logic            reset,
    input  cpuPkg::busReq_t      req_i,
    input  wire logic [3:0]      delay_i,
    input  wire logic            err_i,
    output cpuPkg::busRsp_t      rsp_o
);

    logic [31:0] mem [0:1023];
    logic [3:0]  waitCnt;
    logic        ack;
    logic [31:0] rdat;
    logic [9:0]  idx;

    assign idx       = req_i.adr[9:0];
    assign rsp_o.dat = rdat;
    assign rsp_o.ack = ack;
    assign rsp_o.err = err_i & req_i.cyc;
    assign rsp_o.rty = 1'b0;

    task automatic fillPattern();
        for (int k = 0; k < 1024; k++)
            mem[k] = 32'h9e370000 ^ (k * 32'h00010003);   // differs per word
    endtask

    always @(posedge clk) begin
        if (reset) begin
            ack     <= 1'b0;
            waitCnt <= 4'd0;
        end else if (req_i.stb && req_i.cyc && !ack) begin
            if (waitCnt >= delay_i) begin
                ack     <= 1'b1;
                waitCnt <= 4'd0;
                rdat    <= mem[idx];
                if (req_i.we)
                    mem[idx] <= req_i.dat;
            end else begin
                waitCnt <= waitCnt + 4'd1;
            end
        end else begin
            ack     <= 1'b0;      // single cycle ack
            waitCnt <= 4'd0;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/cpuTb.sv ====
`default_nettype none
`timescale 1ns/1ps

module cpuTb;

    localparam int MAX_TESTS = 32;
    localparam int MAX_PROG  = 8;
    localparam int W_MODE    = 0;       // expect one data write
    localparam int F_MODE    = 1;       // expect a fetch address sequence
    localparam int H_MODE    = 2;       // expect halt

    logic            clk, reset, dataErr, halt;
    logic [3:0]      dataDelay;
    cpuPkg::busReq_t insnReq, dataReq;
    cpuPkg::busRsp_t insnRsp, dataRsp;

    logic [31:0] prog [0:MAX_TESTS*MAX_PROG-1];
    logic [31:0] expFetch [0:MAX_TESTS*4-1];
    logic [31:0] expAdr [0:MAX_TESTS-1];
    logic [31:0] expVal [0:MAX_TESTS-1];
    logic [31:0] preVal [0:MAX_TESTS-1];
    logic [3:0]  delay [0:MAX_TESTS-1];
    logic        errOn [0:MAX_TESTS-1];
    int          nProg [0:MAX_TESTS-1];
    int          mode [0:MAX_TESTS-1];
    int          nExpFetch [0:MAX_TESTS-1];
    int          nt, errors, failedTests, testErrors, cnt;
    logic [31:0] lfsr = 32'hef3a;
    int          nWrites, nFetches;
    logic [31:0] wrAdr, wrDat;
    logic [31:0] fetchLog [0:7];

    cpuTop cpuTop_inst (
        .clk       (clk),
        .reset     (reset),
        .insnReq_o (insnReq),
        .dataReq_o (dataReq),
        .insnRsp_i (insnRsp),
        .dataRsp_i (dataRsp),
        .halt_o    (halt)
    );

    busModel imem (.clk(clk), .reset(reset), .req_i(insnReq), .delay_i(4'd1), .err_i(1'b0),
                   .rsp_o(insnRsp));
    busModel dmem (.clk(clk), .reset(reset), .req_i(dataReq), .delay_i(dataDelay),
                   .err_i(dataErr), .rsp_o(dataRsp));

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        #(MAX_TESTS * MAX_PROG * 40 * 40);
        $display("watchdog timeout, the run did not finish in time");
        $display("Test failures found");
        $finish;
    end

    // bus monitor, sampled mid cycle
    always @(negedge clk) begin
        if (insnReq.stb && insnRsp.ack && nFetches < 8) begin
            fetchLog[nFetches] <= insnReq.adr;
            nFetches           <= nFetches + 1;
        end
        if (dataReq.stb && dataRsp.ack && dataReq.we) begin
            if (nWrites == 0) begin
                wrAdr <= dataReq.adr;
                wrDat <= dataReq.dat;
            end
            nWrites <= nWrites + 1;
        end
    end

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        logic        fb;
        v = 32'd0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [31:0] opModel(input logic [3:0] op, input logic [31:0] a, b);
        case (op)
            cpuPkg::OP_OR:      return a | b;
            cpuPkg::OP_AND:     return a & b;
            cpuPkg::OP_XOR:     return a ^ b;
            cpuPkg::OP_SRA:     return $signed(a) >>> b[4:0];
            cpuPkg::OP_ADD:     return a + b;
            cpuPkg::OP_MUL:     return a * b;
            cpuPkg::OP_EQ:      return (a == b) ? 32'hffffffff : 32'd0;
            cpuPkg::OP_LT:      return ($signed(a) < $signed(b)) ? 32'hffffffff : 32'd0;
            cpuPkg::OP_ORN:     return a | ~b;
            cpuPkg::OP_ANDN:    return a & ~b;
            cpuPkg::OP_PACK:    return (a << 12) | {20'd0, b[11:0]};
            cpuPkg::OP_SRL:     return a >> b[4:0];
            cpuPkg::OP_SUB:     return a - b;
            cpuPkg::OP_SHL:     return a << b[4:0];
            cpuPkg::OP_TESTBIT: return a[b[4:0]] ? 32'hffffffff : 32'd0;
            default:            return ($signed(a) >= $signed(b)) ? 32'hffffffff : 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] modelResult(input logic [1:0] kind, input logic [3:0] op,
                                                input logic [31:0] x, y, imm);
        case (kind)
            2'd0:    return opModel(op, x, y) + imm;
            2'd1:    return opModel(op, x, imm) + y;
            2'd2:    return opModel(op, imm, x) + y;
            default: return opModel(cpuPkg::OP_OR, 32'd0, x) + imm;
        endcase
    endfunction

    function automatic logic [31:0] shortInsn(input logic [1:0] kind, dd,
                                              input logic [3:0] z, x, y, op,
                                              input logic [11:0] imm);
        return {kind, dd, z, x, y, op, imm};
    endfunction

    function automatic logic [31:0] longInsn(input logic [1:0] dd, input logic [3:0] z, x,
                                             input logic [19:0] imm);
        return {2'd3, dd, z, x, imm};
    endfunction

    task automatic emit(input logic [31:0] w);
        prog[nt*MAX_PROG + nProg[nt]] = w;
        nProg[nt]++;
    endtask

    task automatic openTest(input int m, input logic [3:0] d, input logic e);
        mode[nt]      = m;
        delay[nt]     = d;
        errOn[nt]     = e;
        nProg[nt]     = 0;
        nExpFetch[nt] = 0;
        preVal[nt]    = randBits(32);
    endtask

    task automatic closeTest();
        logic [31:0] here;
        here = cpuPkg::RESET_VECTOR + nProg[nt];
        emit(longInsn(2'b00, cpuPkg::PC_IDX, 4'd0, here[19:0]));   // park in a self loop
        nt++;
    endtask

    task automatic loadConst(input logic [3:0] r, input logic [31:0] v);
        emit(longInsn(2'b00, r, 4'd0, v[31:12]));
        emit(shortInsn(2'd1, 2'b00, r, r, 4'd0, cpuPkg::OP_PACK, v[11:0]));
    endtask

    task automatic addArith(input logic [1:0] kind, input logic [3:0] op, input logic [31:0] a, b);
        logic [19:0] imm;
        logic [31:0] immW, dAdr;
        imm  = randBits(20);
        dAdr = 32'h300 + nt;
        openTest(W_MODE, 4'd0, 1'b0);
        loadConst(4'd1, a);
        loadConst(4'd2, b);
        if (kind == 2'd3) begin
            emit(longInsn(2'b00, 4'd3, 4'd1, imm));
            immW = {{12{imm[19]}}, imm};
        end else begin
            emit(shortInsn(kind, 2'b00, 4'd3, 4'd1, 4'd2, op, imm[11:0]));
            immW = {{20{imm[11]}}, imm[11:0]};
        end
        emit(longInsn(2'b01, 4'd3, 4'd0, dAdr[19:0]));
        expAdr[nt] = dAdr;
        expVal[nt] = modelResult(kind, op, a, b, immW);
        closeTest();
    endtask

    task automatic buildTable();
        logic [31:0] a, b;
        nt = 0;
        openTest(F_MODE, 4'd0, 1'b0);
        for (int k = 0; k < 3; k++)
            emit(longInsn(2'b00, 4'd1, 4'd0, k));
        for (int k = 0; k < 4; k++)
            expFetch[nt*4 + k] = cpuPkg::RESET_VECTOR + k;
        nExpFetch[nt] = 4;
        closeTest();
        for (int op = 0; op < 16; op++) begin
            a = randBits(32);
            b = (op == cpuPkg::OP_EQ) ? a : randBits(32);
            addArith(2'd0, op, a, b);
        end
        for (int k = 0; k < 4; k++) begin
            a = randBits(32);
            b = randBits(32);
            addArith(k, cpuPkg::OP_SUB, a, b);
        end
        openTest(W_MODE, 4'd0, 1'b0);                      // r0 ignores writes
        emit(longInsn(2'b00, 4'd0, 4'd0, 20'h555));
        emit(longInsn(2'b01, 4'd0, 4'd0, 20'h320));
        expAdr[nt] = 32'h320;
        expVal[nt] = 32'd0;
        closeTest();
        openTest(W_MODE, 4'd3, 1'b0);                      // load then store back
        emit(longInsn(2'b11, 4'd4, 4'd0, 20'h350));
        emit(longInsn(2'b01, 4'd4, 4'd0, 20'h360));
        expAdr[nt] = 32'h360;
        expVal[nt] = preVal[nt];
        closeTest();
        openTest(W_MODE, 4'd2, 1'b0);
        emit(longInsn(2'b00, 4'd5, 4'd0, 20'h370));
        emit(longInsn(2'b10, 4'd5, 4'd0, 20'h1234));
        expAdr[nt] = 32'h370;
        expVal[nt] = 32'h1234;
        closeTest();
        openTest(F_MODE, 4'd0, 1'b0);                      // branch over one word
        emit(longInsn(2'b00, cpuPkg::PC_IDX, 4'd0, 20'h102));
        emit(longInsn(2'b00, 4'd1, 4'd0, 20'h7));
        expFetch[nt*4]     = 32'h100;
        expFetch[nt*4 + 1] = 32'h102;
        nExpFetch[nt]      = 2;
        closeTest();
        openTest(W_MODE, 4'd0, 1'b0);
        emit(longInsn(2'b00, 4'd1, 4'd0, 20'h1));
        emit(longInsn(2'b01, cpuPkg::PC_IDX, 4'd0, 20'h340));
        expAdr[nt] = 32'h340;
        expVal[nt] = 32'h102;
        closeTest();
        openTest(H_MODE, 4'd1, 1'b1);
        emit(longInsn(2'b01, 4'd0, 4'd0, 20'h330));
        closeTest();
    endtask

    task automatic checkValue(input string name, input logic [31:0] got, exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    initial begin
        reset       = 1'b1;
        dataErr     = 1'b0;
        dataDelay   = 4'd0;
        errors      = 0;
        failedTests = 0;
        nWrites     = 0;
        nFetches    = 0;
        buildTable();
        for (int t = 0; t < nt; t++) begin
            @(negedge clk);
            reset     = 1'b1;
            dataErr   = 1'b0;
            dataDelay = delay[t];
            imem.fillPattern();
            dmem.fillPattern();
            for (int k = 0; k < nProg[t]; k++)
                imem.mem[10'h100 + k] = prog[t*MAX_PROG + k];
            dmem.mem[10'h350] = preVal[t];
            testErrors = errors;
            repeat (3) begin
                @(negedge clk);
                checkValue("insnReq.stb", insnReq.stb, 32'd0);
                checkValue("insnReq.cyc", insnReq.cyc, 32'd0);
                checkValue("dataReq.stb", dataReq.stb, 32'd0);
                checkValue("dataReq.cyc", dataReq.cyc, 32'd0);
                checkValue("dataReq.we", dataReq.we, 32'd0);
            end
            nWrites  = 0;                   // bus models are quiet in reset here
            nFetches = 0;
            reset    = 1'b0;
            dataErr  = errOn[t];
            cnt      = 0;
            while (!insnReq.stb && cnt < 2) begin
                @(negedge clk);
                cnt++;
            end
            if (!insnReq.stb) begin
                $display("first instruction fetch did not appear within 2 cycles of reset");
                errors++;
            end
            checkValue("insnReq.cyc", insnReq.cyc, 32'd1);
            checkValue("insnReq.adr", insnReq.adr, cpuPkg::RESET_VECTOR);
            if (mode[t] == W_MODE) begin
                while (nWrites == 0)
                    @(negedge clk);
                checkValue("dataReq.adr", wrAdr, expAdr[t]);
                checkValue("dataReq.dat", wrDat, expVal[t]);
            end else if (mode[t] == F_MODE) begin
                while (nFetches < nExpFetch[t])
                    @(negedge clk);
                for (int k = 0; k < nExpFetch[t]; k++)
                    checkValue("insnReq.adr", fetchLog[k], expFetch[t*4 + k]);
            end else begin
                while (!halt)
                    @(negedge clk);
                repeat (20) begin
                    @(negedge clk);
                    checkValue("insnReq.stb", insnReq.stb, 32'd0);
                    checkValue("halt_o", halt, 32'd1);
                end
            end
            if (errors != testErrors)
                failedTests++;
            $display("test %0d: %s", t, (errors == testErrors) ? "ok" : "FAILED");
        end
        $display("%0d tests run, %0d failed, %0d check errors", nt, failedTests, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
hdl/cpuPkg.sv
hdl/insnDecode.sv
hdl/regFile.sv
hdl/execUnit.sv
hdl/busSequencer.sv
hdl/cpuTop.sv
testbench/busModel.sv
testbench/cpuTb.sv
